// File: soc_pkg.sv
// **********************************************************************
// SoC glue shared definitions
// **********************************************************************
`default_nettype none

package soc_pkg;

   // cpu and memory address width
   localparam int addr_bits = 16;
   // byte width on every data path
   localparam int data_bits = 8;

   // a15 clear is rom, a15 set is ram
   localparam int rom_split_bit = 15;

   // cycles core_reset stays high after the last cause
   localparam int reset_hold_cycles = 255;

   // sd bit-bang pins in the i/o byte
   localparam int sd_cs_bit   = 0;
   localparam int sd_sck_bit  = 1;
   localparam int sd_mosi_bit = 2;
   localparam int sd_miso_bit = 3;

   // card deselected, clock and data idle high
   localparam logic [2:0] sd_ctrl_reset = 3'b111;

endpackage

`default_nettype wire

// File: reset_sequencer.sv
// **********************************************************************
// Core reset hold-off
// **********************************************************************
`default_nettype none

module reset_sequencer (
   input  logic cpu_clock,
   input  logic cpu_reset,
   input  logic reset_request,
   input  logic load_active,
   output logic core_reset
);

   import soc_pkg::*;

   // hold-off counter, parks at the limit
   logic [7:0] hold_count;
   logic       any_cause;

   // board reset, osd reset entry or a running download
   assign any_cause = cpu_reset | reset_request | load_active;

   always_ff @(posedge cpu_clock) begin
      if (any_cause) begin
         // restart the wait on every cause
         hold_count <= 8'd0;
      end else if (hold_count < 8'(reset_hold_cycles)) begin
         hold_count <= hold_count + 8'd1;
      end
   end

   // core stays in reset until the count is complete
   // gives memory and downloads time to settle
   assign core_reset = (hold_count < 8'(reset_hold_cycles));

endmodule

`default_nettype wire

// File: rom_loader.sv
// **********************************************************************
// ROM download port
// **********************************************************************
`default_nettype none

module rom_loader (
   input  logic                          cpu_clock,
   input  logic                          cpu_reset,
   input  logic                          load_active,
   input  logic                          load_req,
   input  logic [soc_pkg::data_bits-1:0] load_data,
   output logic                          load_ack,
   output logic                          loader_wr,
   output logic [soc_pkg::addr_bits-1:0] loader_addr,
   output logic [soc_pkg::data_bits-1:0] loader_data
);

   import soc_pkg::*;

   // previous load_active, for start of download
   logic load_active_d;
   logic load_start;

   assign load_start = load_active & ~load_active_d;

   // four-phase handshake fsm
   // load_ack low is the idle state, high is waiting for req to drop
   always_ff @(posedge cpu_clock) begin
      if (cpu_reset) begin
         load_ack      <= 1'b0;
         loader_wr     <= 1'b0;
         load_active_d <= 1'b0;
      end else begin
         load_active_d <= load_active;
         // write strobe is a single cycle per byte
         loader_wr     <= 1'b0;
         if (!load_ack) begin
            if (load_req) begin
               // take the byte, request a write, acknowledge
               loader_wr <= 1'b1;
               load_ack  <= 1'b1;
            end
         end else if (!load_req) begin
            // source released req, close the handshake
            load_ack <= 1'b0;
         end
      end
   end

   // address counter
   always_ff @(posedge cpu_clock) begin
      if (cpu_reset) begin
         loader_addr <= '0;
      end else if (load_start) begin
         // new download starts at address 0
         loader_addr <= '0;
      end else if (loader_wr) begin
         // step once the byte has gone into memory
         loader_addr <= loader_addr + 1'b1;
      end
   end

   // byte held stable for the write cycle
   always_ff @(posedge cpu_clock) begin
      if (!load_ack && load_req) begin
         loader_data <= load_data;
      end
   end

endmodule

`default_nettype wire

// File: mem_arbiter.sv
// **********************************************************************
// Memory arbiter and 64K byte memory
// **********************************************************************
`default_nettype none

module mem_arbiter (
   input  logic                          cpu_clock,
   input  logic                          loader_wr,
   input  logic [soc_pkg::addr_bits-1:0] loader_addr,
   input  logic [soc_pkg::data_bits-1:0] loader_data,
   input  logic                          load_active,
   input  logic [soc_pkg::addr_bits-1:0] cpu_addr,
   input  logic [soc_pkg::data_bits-1:0] cpu_dout,
   input  logic                          cpu_mreq,
   input  logic                          cpu_rd,
   input  logic                          cpu_wr,
   output logic [soc_pkg::data_bits-1:0] mem_rdata
);

   import soc_pkg::*;

   // one byte per cpu address
   logic [data_bits-1:0] mem [0:(2**addr_bits)-1];

   logic                 cpu_mem_wr;
   logic                 cpu_mem_rd;
   logic                 wr_en;
   logic [addr_bits-1:0] wr_addr;
   logic [data_bits-1:0] wr_data;

   // cpu writes only reach the ram half
   // lower half is rom, filled by the loader
   assign cpu_mem_wr = cpu_mreq & cpu_wr & cpu_addr[rom_split_bit];
   assign cpu_mem_rd = cpu_mreq & cpu_rd;

   // loader owns the memory during a download
   always_comb begin
      if (load_active) begin
         wr_en   = loader_wr;
         wr_addr = loader_addr;
         wr_data = loader_data;
      end else begin
         wr_en   = cpu_mem_wr;
         wr_addr = cpu_addr;
         wr_data = cpu_dout;
      end
   end

   // write lands on the strobe edge
   always_ff @(posedge cpu_clock) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // registered read, data valid the cycle after the strobe
   always_ff @(posedge cpu_clock) begin
      if (cpu_mem_rd) begin
         mem_rdata <= mem[cpu_addr];
      end
   end

endmodule

`default_nettype wire

// File: io_ports.sv
// **********************************************************************
// SD bit-bang port and vsync interrupt
// **********************************************************************
`default_nettype none

module io_ports (
   input  logic                          cpu_clock,
   input  logic                          cpu_reset,
   input  logic                          cpu_iorq,
   input  logic                          cpu_m1,
   input  logic                          cpu_wr,
   input  logic [soc_pkg::data_bits-1:0] cpu_dout,
   input  logic                          sd_miso,
   input  logic                          vsync,
   output logic                          sd_cs,
   output logic                          sd_sck,
   output logic                          sd_mosi,
   output logic [soc_pkg::data_bits-1:0] io_rdata,
   output logic                          irq
);

   import soc_pkg::*;

   logic [2:0]           sd_ctrl;
   logic [data_bits-1:0] io_word;
   logic                 io_write;
   logic                 irq_ack;
   logic                 vsync_meta;
   logic                 vsync_sync;
   logic                 vsync_prev;

   // iorq with m1 is an interrupt acknowledge, not a port access
   assign io_write = cpu_iorq & ~cpu_m1 & cpu_wr;
   assign irq_ack  = cpu_iorq & cpu_m1;

   // sd control bits, loaded by any i/o write
   always_ff @(posedge cpu_clock) begin
      if (cpu_reset) begin
         sd_ctrl <= sd_ctrl_reset;
      end else if (io_write) begin
         sd_ctrl[sd_cs_bit]   <= cpu_dout[sd_cs_bit];
         sd_ctrl[sd_sck_bit]  <= cpu_dout[sd_sck_bit];
         sd_ctrl[sd_mosi_bit] <= cpu_dout[sd_mosi_bit];
      end
   end

   assign sd_cs   = sd_ctrl[sd_cs_bit];
   assign sd_sck  = sd_ctrl[sd_sck_bit];
   assign sd_mosi = sd_ctrl[sd_mosi_bit];

   // read byte, upper nibble zero, miso above the control bits
   always_comb begin
      io_word              = '0;
      io_word[2:0]         = sd_ctrl;
      io_word[sd_miso_bit] = sd_miso;
   end

   // sampled every cycle, so a read strobe sees it one cycle later
   always_ff @(posedge cpu_clock) begin
      io_rdata <= io_word;
   end

   // two-flop sync for the video vsync
   always_ff @(posedge cpu_clock) begin
      vsync_meta <= vsync;
      vsync_sync <= vsync_meta;
      vsync_prev <= vsync_sync;
   end

   // irq set on vsync rise, held until acknowledged
   always_ff @(posedge cpu_clock) begin
      if (cpu_reset) begin
         irq <= 1'b0;
      end else if (irq_ack) begin
         // acknowledge wins over a new edge
         irq <= 1'b0;
      end else if (vsync_sync && !vsync_prev) begin
         irq <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: soc_glue.sv
// **********************************************************************
// SoC glue top level
// **********************************************************************
`default_nettype none

module soc_glue (
   input  logic                          cpu_clock,
   input  logic                          cpu_reset,
   // cpu bus, driven from outside
   input  logic [soc_pkg::addr_bits-1:0] cpu_addr,
   input  logic [soc_pkg::data_bits-1:0] cpu_dout,
   input  logic                          cpu_mreq,
   input  logic                          cpu_iorq,
   input  logic                          cpu_rd,
   input  logic                          cpu_wr,
   input  logic                          cpu_m1,
   output logic [soc_pkg::data_bits-1:0] cpu_din,
   // rom download port
   input  logic                          load_active,
   input  logic                          load_req,
   input  logic [soc_pkg::data_bits-1:0] load_data,
   output logic                          load_ack,
   // misc
   input  logic                          reset_request,
   input  logic                          vsync,
   input  logic                          sd_miso,
   output logic                          core_reset,
   output logic                          irq,
   output logic                          sd_cs,
   output logic                          sd_sck,
   output logic                          sd_mosi
);

   import soc_pkg::*;

   logic                 loader_wr;
   logic [addr_bits-1:0] loader_addr;
   logic [data_bits-1:0] loader_data;
   logic [data_bits-1:0] mem_rdata;
   logic [data_bits-1:0] io_rdata;
   // last read went to i/o space
   logic                 read_io;

   // core reset after board reset, osd reset or download
   reset_sequencer u_reset_sequencer (
      .cpu_clock     (cpu_clock),
      .cpu_reset     (cpu_reset),
      .reset_request (reset_request),
      .load_active   (load_active),
      .core_reset    (core_reset)
   );

   rom_loader u_rom_loader (
      .cpu_clock   (cpu_clock),
      .cpu_reset   (cpu_reset),
      .load_active (load_active),
      .load_req    (load_req),
      .load_data   (load_data),
      .load_ack    (load_ack),
      .loader_wr   (loader_wr),
      .loader_addr (loader_addr),
      .loader_data (loader_data)
   );

   // rom in the lower half, ram in the upper half
   mem_arbiter u_mem_arbiter (
      .cpu_clock   (cpu_clock),
      .loader_wr   (loader_wr),
      .loader_addr (loader_addr),
      .loader_data (loader_data),
      .load_active (load_active),
      .cpu_addr    (cpu_addr),
      .cpu_dout    (cpu_dout),
      .cpu_mreq    (cpu_mreq),
      .cpu_rd      (cpu_rd),
      .cpu_wr      (cpu_wr),
      .mem_rdata   (mem_rdata)
   );

   io_ports u_io_ports (
      .cpu_clock (cpu_clock),
      .cpu_reset (cpu_reset),
      .cpu_iorq  (cpu_iorq),
      .cpu_m1    (cpu_m1),
      .cpu_wr    (cpu_wr),
      .cpu_dout  (cpu_dout),
      .sd_miso   (sd_miso),
      .vsync     (vsync),
      .sd_cs     (sd_cs),
      .sd_sck    (sd_sck),
      .sd_mosi   (sd_mosi),
      .io_rdata  (io_rdata),
      .irq       (irq)
   );

   // remember the space of each read strobe
   // both sources register their data on the same edge
   always_ff @(posedge cpu_clock) begin
      if (cpu_reset) begin
         read_io <= 1'b0;
      end else if (cpu_rd && (cpu_mreq || cpu_iorq)) begin
         read_io <= cpu_iorq;
      end
   end

   assign cpu_din = read_io ? io_rdata : mem_rdata;

endmodule

`default_nettype wire

// File: soc_checker.sv
// **********************************************************************
// SoC glue reference model and checker
// **********************************************************************
`default_nettype none

module soc_checker (
   input  logic                          cpu_clock,
   input  logic                          cpu_reset,
   input  logic [soc_pkg::addr_bits-1:0] cpu_addr,
   input  logic [soc_pkg::data_bits-1:0] cpu_dout,
   input  logic                          cpu_mreq,
   input  logic                          cpu_iorq,
   input  logic                          cpu_rd,
   input  logic                          cpu_wr,
   input  logic                          cpu_m1,
   input  logic [soc_pkg::data_bits-1:0] cpu_din,
   input  logic                          load_active,
   input  logic                          load_req,
   input  logic [soc_pkg::data_bits-1:0] load_data,
   input  logic                          load_ack,
   input  logic                          reset_request,
   input  logic                          vsync,
   input  logic                          sd_miso,
   input  logic                          core_reset,
   input  logic                          irq,
   input  logic                          sd_cs,
   input  logic                          sd_sck,
   input  logic                          sd_mosi
);

   import soc_pkg::*;

   // byte model of the whole address space
   logic [data_bits-1:0] mem_model [0:(2**addr_bits)-1];
   // cycles since the last reset cause, saturating
   int                   since_cause = 0;
   logic                 exp_ack = 1'b0;
   logic [addr_bits-1:0] load_addr = '0;
   logic                 active_prev = 1'b0;
   logic [2:0]           exp_ctrl = sd_ctrl_reset;
   logic [2:0]           pins;
   // vsync samples of the last three cycles, newest in bit 0
   logic [2:0]           vsync_hist = 3'b000;
   logic                 vsync_edge;
   logic                 exp_irq = 1'b0;
   logic                 read_pending = 1'b0;
   logic [data_bits-1:0] read_expect = '0;
   // compare only once reset has been seen
   logic                 armed = 1'b0;

   string test_name   = "none";
   int    test_checks = 0;
   int    test_errors = 0;
   int    tests_done  = 0;
   int    check_count = 0;
   int    error_count = 0;

   assign pins[sd_cs_bit]   = sd_cs;
   assign pins[sd_sck_bit]  = sd_sck;
   assign pins[sd_mosi_bit] = sd_mosi;

   task open_test(input string name);
      test_name   = name;
      test_checks = 0;
      test_errors = 0;
   endtask

   task close_test();
      tests_done++;
      $display("test %s finished, %0d checks, %0d errors", test_name, test_checks, test_errors);
   endtask

   task report_counts();
      $display("tests %0d, checks %0d, errors %0d", tests_done, check_count, error_count);
   endtask

   task compare(input string what, input logic [7:0] exp, input logic [7:0] act);
      check_count++;
      test_checks++;
      if (act !== exp) begin
         error_count++;
         test_errors++;
         $display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp, act);
      end
   endtask

   // outputs and inputs are both settled at the falling edge
   always @(negedge cpu_clock) begin
      if (armed) begin
         compare("core_reset", since_cause < reset_hold_cycles, core_reset);
         compare("load_ack", exp_ack, load_ack);
         compare("sd pins", exp_ctrl, pins);
         compare("irq", exp_irq, irq);
         if (read_pending) begin
            compare("cpu_din", read_expect, cpu_din);
         end
      end

      // read data seen one cycle after the strobe
      read_pending = cpu_rd && (cpu_mreq || cpu_iorq);
      if (cpu_iorq) begin
         read_expect = {4'b0000, sd_miso, exp_ctrl};
      end else begin
         read_expect = mem_model[cpu_addr];
      end

      // core reset hold-off
      if (cpu_reset || reset_request || load_active) begin
         since_cause = 0;
      end else if (since_cause < reset_hold_cycles) begin
         since_cause++;
      end

      // download port, address restarts with each new download
      if (cpu_reset || (load_active && !active_prev)) begin
         load_addr = '0;
      end
      active_prev = load_active;
      if (cpu_reset) begin
         exp_ack = 1'b0;
      end else if (!exp_ack && load_req) begin
         exp_ack = 1'b1;
         if (load_active) begin
            mem_model[load_addr] = load_data;
         end
         load_addr++;
      end else if (exp_ack && !load_req) begin
         exp_ack = 1'b0;
      end

      // cpu writes reach the ram half only
      if (!load_active && cpu_mreq && cpu_wr && cpu_addr[rom_split_bit]) begin
         mem_model[cpu_addr] = cpu_dout;
      end

      // sd control bits
      if (cpu_reset) begin
         exp_ctrl = sd_ctrl_reset;
      end else if (cpu_iorq && cpu_wr && !cpu_m1) begin
         exp_ctrl = cpu_dout[2:0];
      end

      // irq is high three cycles after the vsync rise
      vsync_edge = vsync_hist[1] && !vsync_hist[2];
      vsync_hist = {vsync_hist[1:0], vsync};
      if (cpu_reset || (cpu_iorq && cpu_m1)) begin
         exp_irq = 1'b0;
      end else if (vsync_edge) begin
         exp_irq = 1'b1;
      end

      if (cpu_reset) begin
         armed = 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: tb_soc.sv
// **********************************************************************
// SoC glue testbench
// **********************************************************************
`default_nettype none

module tb_soc;

   import soc_pkg::*;

   logic                 cpu_clock;
   logic                 cpu_reset;
   logic [addr_bits-1:0] cpu_addr;
   logic [data_bits-1:0] cpu_dout;
   logic                 cpu_mreq;
   logic                 cpu_iorq;
   logic                 cpu_rd;
   logic                 cpu_wr;
   logic                 cpu_m1;
   logic [data_bits-1:0] cpu_din;
   logic                 load_active;
   logic                 load_req;
   logic [data_bits-1:0] load_data;
   logic                 load_ack;
   logic                 reset_request;
   logic                 vsync;
   logic                 sd_miso;
   logic                 core_reset;
   logic                 irq;
   logic                 sd_cs;
   logic                 sd_sck;
   logic                 sd_mosi;

   integer seed    = 32'hb6f5_052f;
   logic   aborted = 1'b0;

   soc_glue dut (.*);

   soc_checker chk (.*);

   initial begin
      cpu_clock = 1'b0;
      forever #5 cpu_clock = ~cpu_clock;
   end

   // inputs change just after the rising edge
   task next_cycle();
      @(posedge cpu_clock);
      #1;
   endtask

   function logic watched(input string sel);
      if (sel == "load_ack") return load_ack;
      else if (sel == "core_reset") return core_reset;
      else return irq;
   endfunction

   task wait_for(input string sel, input logic level, input int limit);
      int count;
      count = 0;
      while (watched(sel) !== level && count < limit) begin
         next_cycle();
         count++;
      end
      if (watched(sel) !== level) begin
         $display("timeout: %s did not reach %0d within %0d cycles", sel, level, limit);
         aborted = 1'b1;
      end
   endtask

   // one bus cycle with single-clock strobes
   task bus_cycle(input logic mreq, input logic iorq, input logic rd, input logic wr,
                  input logic m1, input logic [15:0] addr, input logic [7:0] data);
      cpu_addr = addr;
      cpu_dout = data;
      cpu_mreq = mreq;
      cpu_iorq = iorq;
      cpu_rd   = rd;
      cpu_wr   = wr;
      cpu_m1   = m1;
      next_cycle();
      {cpu_mreq, cpu_iorq, cpu_rd, cpu_wr, cpu_m1} = 5'b00000;
   endtask

   task reset_hold_sequence();
      chk.open_test("reset_hold");
      repeat (16) next_cycle();
      cpu_reset = 1'b0;
      wait_for("core_reset", 1'b0, 300);
      if (!aborted) begin
         // osd reset pulse restarts the hold-off
         reset_request = 1'b1;
         next_cycle();
         reset_request = 1'b0;
         wait_for("core_reset", 1'b0, 300);
      end
      next_cycle();
      chk.close_test();
   endtask

   task download_and_read();
      int i;
      int gap;
      chk.open_test("download");
      load_active = 1'b1;
      repeat (4) next_cycle();
      for (i = 0; i < 256 && !aborted; i++) begin
         gap = $random(seed) & 3;
         repeat (gap) next_cycle();
         load_data = $random(seed);
         load_req  = 1'b1;
         wait_for("load_ack", 1'b1, 8);
         load_req = 1'b0;
         if (!aborted) wait_for("load_ack", 1'b0, 8);
      end
      next_cycle();
      load_active = 1'b0;
      // read back every loaded address
      for (i = 0; i < 256 && !aborted; i++) begin
         bus_cycle(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, i, 8'h00);
      end
      if (!aborted) wait_for("core_reset", 1'b0, 300);
      next_cycle();
      chk.close_test();
   endtask

   task cpu_memory_map();
      logic [15:0] addr_list [$];
      logic [15:0] a;
      int          i;
      chk.open_test("cpu_memory");
      for (i = 0; i < 64; i++) begin
         a = $random(seed);
         // odd passes hit ram, even passes hit the loaded rom bytes
         if (i % 2) a = a | 16'h8000;
         else a = a & 16'h00ff;
         addr_list.push_back(a);
         bus_cycle(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, a, $random(seed));
      end
      for (i = 0; i < addr_list.size(); i++) begin
         bus_cycle(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, addr_list[i], 8'h00);
      end
      next_cycle();
      chk.close_test();
   endtask

   task sd_port_access();
      int i;
      chk.open_test("sd_port");
      for (i = 0; i < 32; i++) begin
         sd_miso = $random(seed);
         bus_cycle(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, $random(seed), $random(seed));
         bus_cycle(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, $random(seed), 8'h00);
      end
      next_cycle();
      chk.close_test();
   endtask

   task vsync_interrupt();
      int i;
      chk.open_test("vsync_irq");
      vsync = 1'b1;
      wait_for("irq", 1'b1, 6);
      repeat (4) next_cycle();
      vsync = 1'b0;
      // irq must survive ordinary traffic
      for (i = 0; i < 16 && !aborted; i++) begin
         if (i % 2) bus_cycle(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, $random(seed) & 16'h00ff, 8'h00);
         else bus_cycle(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, $random(seed), 8'h00);
      end
      // interrupt acknowledge cycle
      bus_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 16'h0000, 8'h00);
      if (!aborted) wait_for("irq", 1'b0, 3);
      next_cycle();
      chk.close_test();
   endtask

   initial begin
      cpu_reset     = 1'b1;
      cpu_addr      = '0;
      cpu_dout      = '0;
      cpu_mreq      = 1'b0;
      cpu_iorq      = 1'b0;
      cpu_rd        = 1'b0;
      cpu_wr        = 1'b0;
      cpu_m1        = 1'b0;
      load_active   = 1'b0;
      load_req      = 1'b0;
      load_data     = '0;
      reset_request = 1'b0;
      vsync         = 1'b0;
      sd_miso       = 1'b0;
      reset_hold_sequence();
      if (!aborted) download_and_read();
      if (!aborted) cpu_memory_map();
      if (!aborted) sd_port_access();
      if (!aborted) vsync_interrupt();
      chk.report_counts();
      if (aborted || chk.error_count != 0) begin
         $display("=== FAIL ===");
      end else begin
         $display("=== PASS ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
soc_pkg.sv
reset_sequencer.sv
rom_loader.sv
mem_arbiter.sv
io_ports.sv
soc_glue.sv
soc_checker.sv
tb_soc.sv
